// File: dv/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys;
    import mips_mem_pkg::*;

    localparam int ADDR_W      = 8;
    localparam int RST_CYCLES  = 10;
    localparam int NWORDS      = 64;  // words filled by the first test
    localparam int EXT_WORDS   = 4;
    localparam int FETCH_N     = 48;
    localparam int FETCH_BUDGET = 8 * FETCH_N;
    localparam int T1_CYCLES   = 2 * NWORDS + 4;
    localparam int T2_CYCLES   = 24;
    localparam int T3_CYCLES   = 12 * EXT_WORDS + 4;
    localparam int T4_CYCLES   = 40;
    localparam int T5_CYCLES   = FETCH_BUDGET + 8;
    localparam int CYCLE_LIMIT = RST_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                               + T4_CYCLES + T5_CYCLES + 50;

    logic        clk = 1'b0;
    logic        rst;
    data_req_t   req;
    logic        fetch_start;
    logic [31:0] fetch_pc;
    logic        fetch_run;
    data_rsp_t   rsp;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;

    logic [31:0] model [2**ADDR_W];  // reference memory
    logic [31:0] lcg_state = 32'd66;
    logic        load_exp = 1'b0;
    logic        load_exp_q = 1'b0;
    logic [31:0] exp_load = 32'd0;
    logic [31:0] exp_load_q = 32'd0;
    logic        exp_err_lw = 1'b0;
    logic        exp_err_sw = 1'b0;
    logic [31:0] exp_pc = 32'd0;
    logic [31:0] exp_instr;
    int          fetch_count = 0;
    int          errors = 0;
    int          errs_at_start = 0;
    int          tests_run = 0;
    int          cycles = 0;
    string       test_name = "reset";

    mem_subsys_top #(
        .ADDR_W      (ADDR_W)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .fetch_start (fetch_start),
        .fetch_pc    (fetch_pc),
        .fetch_run   (fetch_run),
        .rsp         (rsp),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles in test %s", cycles, test_name);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // expectations delayed by the one-cycle RAM read
    always @(posedge clk) begin
        load_exp_q <= load_exp;
        exp_load_q <= exp_load;
        if (fetch_start) begin
            exp_pc      <= {fetch_pc[31:2], 2'b00};
            fetch_count <= 0;
        end else if (instr_valid) begin
            exp_pc      <= exp_pc + 32'd4;
            fetch_count <= fetch_count + 1;
        end
    end

    always_comb exp_instr = model[exp_pc[ADDR_W+1:2]];

    a_rvalid: assert property (@(posedge clk) disable iff (rst)
        rsp.rvalid == load_exp_q)
        else begin
            errors++;
            $display("Mismatch %s rvalid: expected %b, actual %b", test_name,
                     $sampled(load_exp_q), $sampled(rsp.rvalid));
        end

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        rsp.rvalid |-> (rsp.rdata == exp_load_q))
        else begin
            errors++;
            $display("Mismatch %s rdata: expected %h, actual %h", test_name,
                     $sampled(exp_load_q), $sampled(rsp.rdata));
        end

    a_err_flags: assert property (@(posedge clk) disable iff (rst)
        {rsp.addr_error_lw, rsp.addr_error_sw} == {exp_err_lw, exp_err_sw})
        else begin
            errors++;
            $display("Mismatch %s error flags lw/sw: expected %b%b, actual %b%b", test_name,
                     $sampled(exp_err_lw), $sampled(exp_err_sw),
                     $sampled(rsp.addr_error_lw), $sampled(rsp.addr_error_sw));
        end

    a_fetch_pc: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> (instr_pc == exp_pc))
        else begin
            errors++;
            $display("Mismatch %s instr_pc: expected %h, actual %h", test_name,
                     $sampled(exp_pc), $sampled(instr_pc));
        end

    a_fetch_word: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> (instr == exp_instr))
        else begin
            errors++;
            $display("Mismatch %s instr: expected %h, actual %h", test_name,
                     $sampled(exp_instr), $sampled(instr));
        end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [5:0] pick_op(input logic [2:0] k);
        case (k)
            3'd0:    return OP_LW;
            3'd1:    return OP_LH;
            3'd2:    return OP_LHU;
            3'd3:    return OP_LB;
            3'd4:    return OP_LBU;
            3'd5:    return OP_SW;
            3'd6:    return OP_SH;
            default: return OP_SB;
        endcase
    endfunction

    function automatic void clear_req();
        req        = '0;
        load_exp   = 1'b0;
        exp_err_lw = 1'b0;
        exp_err_sw = 1'b0;
    endfunction

    task automatic idle();
        @(negedge clk);
        clear_req();
        @(posedge clk);
    endtask

    // one memory-stage access, model follows the byte-enable rule
    task automatic access(input logic [5:0] op, input logic [31:0] addr,
                          input logic [31:0] wdata);
        logic [1:0]        off;
        logic [ADDR_W-1:0] idx;
        logic [31:0]       word;
        logic [31:0]       sh;
        logic              is_ld;
        logic              is_st;
        off   = addr[1:0];
        idx   = addr[ADDR_W+1:2];
        is_ld = (op == OP_LW) || (op == OP_LH) || (op == OP_LHU)
             || (op == OP_LB) || (op == OP_LBU);
        is_st = (op == OP_SW) || (op == OP_SH) || (op == OP_SB);
        @(negedge clk);
        req.en     = 1'b1;
        req.instr  = {op, 26'd0};
        req.addr   = addr;
        req.wdata  = wdata;
        exp_err_lw = ((op == OP_LW) && (off != 2'b00))
                  || (((op == OP_LH) || (op == OP_LHU)) && off[0]);
        exp_err_sw = ((op == OP_SW) && (off != 2'b00)) || ((op == OP_SH) && off[0]);
        load_exp   = is_ld && !exp_err_lw;
        word = model[idx];
        sh   = word >> (8 * off);
        case (op)
            OP_LW:   exp_load = word;
            OP_LH:   exp_load = {{16{sh[15]}}, sh[15:0]};
            OP_LHU:  exp_load = {16'h0000, sh[15:0]};
            OP_LB:   exp_load = {{24{sh[7]}}, sh[7:0]};
            OP_LBU:  exp_load = {24'h000000, sh[7:0]};
            default: exp_load = 32'd0;
        endcase
        @(posedge clk);
        if (is_st && !exp_err_sw) begin  // written at this edge
            case (op)
                OP_SW:   word = wdata;
                OP_SH:   word[8*off +: 16] = wdata[15:0];
                default: word[8*off +: 8] = wdata[7:0];
            endcase
            model[idx] = word;
        end
    endtask

    task automatic rand_access();
        logic [31:0] r;
        logic [5:0]  op;
        logic [1:0]  off;
        r   = lcg_next();
        op  = pick_op(r[30:28]);
        off = r[25:24];
        if ((op == OP_LW) || (op == OP_SW)) begin
            off = 2'b00;
        end else if ((op == OP_LH) || (op == OP_LHU) || (op == OP_SH)) begin
            off[0] = 1'b0;
        end
        access(op, {24'd0, r[21:16], off}, lcg_next());  // words 0 to 63
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = errors;
    endtask

    task automatic end_test();
        idle();
        idle();  // last response drains
        tests_run++;
        $display("test %s finished with %0d errors", test_name, errors - errs_at_start);
    endtask

    initial begin
        logic [31:0] r;
        int          waited;
        rst         = 1'b1;
        fetch_start = 1'b0;
        fetch_pc    = 32'd0;
        fetch_run   = 1'b0;
        clear_req();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("word_access");
        for (int i = 0; i < NWORDS; i++) access(OP_SW, 4 * i, lcg_next());
        for (int i = 0; i < NWORDS; i++) access(OP_LW, 4 * i, 32'd0);
        end_test();

        begin_test("partial_store");
        for (int k = 0; k < 4; k++) access(OP_SB, 32 + k, lcg_next());
        access(OP_SH, 36, lcg_next());
        access(OP_SH, 38, lcg_next());
        access(OP_SB, 41, lcg_next());
        access(OP_SH, 42, lcg_next());
        for (int w = 8; w < 11; w++) access(OP_LW, 4 * w, 32'd0);
        end_test();

        begin_test("load_extend");
        for (int w = 12; w < 12 + EXT_WORDS; w++) begin
            for (int k = 0; k < 4; k++) begin
                access(OP_LB, 4 * w + k, 32'd0);
                access(OP_LBU, 4 * w + k, 32'd0);
            end
            for (int k = 0; k < 4; k += 2) begin
                access(OP_LH, 4 * w + k, 32'd0);
                access(OP_LHU, 4 * w + k, 32'd0);
            end
        end
        end_test();

        begin_test("misalign");
        for (int k = 1; k < 4; k++) begin
            access(OP_SW, 80 + k, lcg_next());
            access(OP_LW, 80 + k, 32'd0);
        end
        for (int k = 1; k < 4; k += 2) begin
            access(OP_LH, 80 + k, 32'd0);
            access(OP_LHU, 80 + k, 32'd0);
            access(OP_SH, 80 + k, lcg_next());
        end
        access(OP_LW, 80, 32'd0);  // word 20 unchanged
        end_test();

        begin_test("fetch_stream");
        @(negedge clk);
        fetch_pc    = 32'd16;  // away from the reset pc
        fetch_start = 1'b1;
        @(negedge clk);
        fetch_start = 1'b0;
        fetch_run   = 1'b1;
        @(posedge clk);
        waited = 0;
        while ((fetch_count < FETCH_N) && (waited < FETCH_BUDGET)) begin
            r = lcg_next();
            if (r[31:29] < 3'd3) begin
                rand_access();  // stalls the fetch for a cycle
            end else begin
                idle();
            end
            waited++;
        end
        @(negedge clk);
        fetch_run = 1'b0;
        clear_req();
        @(posedge clk);
        if (fetch_count < FETCH_N) begin
            errors++;
            $display("fetch stalled, only %0d of %0d instructions came back",
                     fetch_count, FETCH_N);
        end
        end_test();

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/mips_mem_pkg.sv
hdl/mem_control.sv
hdl/fetch_port.sv
hdl/ram_arbiter.sv
hdl/data_ram.sv
hdl/mem_subsys_top.sv
dv/tb_mem_subsys.sv

// File: hdl/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int ADDR_W = mips_mem_pkg::DEFAULT_ADDR_W
) (
    input  logic                    clk,
    input  mips_mem_pkg::ram_req_t  ram_req,
    output mips_mem_pkg::mem_word_u rdata
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [3:0][7:0]   mem [DEPTH];
    logic [ADDR_W-1:0] waddr;
    logic              rd_en;

    assign waddr = ram_req.word_addr[ADDR_W-1:0];
    assign rd_en = ram_req.en && (ram_req.byte_wen == 4'b0000);

    // per-byte write
    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_req.byte_wen[i]) begin
                    mem[waddr][i] <= ram_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata.raw <= mem[waddr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_port.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_port #(
    parameter int ADDR_W = mips_mem_pkg::DEFAULT_ADDR_W
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_start,
    input  logic [31:0]             fetch_pc,
    input  logic                    fetch_run,
    input  logic                    fetch_grant,
    input  logic                    fetch_rvalid,
    input  mips_mem_pkg::mem_word_u mem_rdata,
    output mips_mem_pkg::ram_req_t  freq,
    output logic                    instr_valid,
    output logic [31:0]             instr,
    output logic [31:0]             instr_pc
);
    import mips_mem_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] flight_pc_q;  // pc of the read in the RAM

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= 32'd0;
        end else if (fetch_start) begin
            pc_q <= {fetch_pc[31:2], 2'b00};
        end else if (fetch_grant) begin
            pc_q <= pc_q + 32'd4;  // holds while data side owns the RAM
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_grant) begin
            flight_pc_q <= pc_q;
        end
    end

    always_comb begin
        freq.en        = fetch_run && !fetch_start;  // no request while pc reloads
        freq.byte_wen  = 4'b0000;
        freq.word_addr = WORD_ADDR_W'(pc_q[ADDR_W+1:2]);
        freq.wdata     = 32'd0;
    end

    assign instr_valid = fetch_rvalid;
    assign instr       = mem_rdata.raw;
    assign instr_pc    = flight_pc_q;

    a_fetch_read_only: assert property (@(posedge clk) disable iff (rst)
        freq.byte_wen == 4'b0000);

    // every returned word was granted one cycle earlier
    a_valid_after_grant: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> $past(fetch_grant && freq.en));

endmodule

`default_nettype wire

// File: hdl/mem_control.sv
`timescale 1ns/1ns
`default_nettype none

module mem_control #(
    parameter int ADDR_W = mips_mem_pkg::DEFAULT_ADDR_W
) (
    input  logic                    clk,
    input  logic                    rst,
    input  mips_mem_pkg::data_req_t req,
    input  mips_mem_pkg::mem_word_u mem_rdata,
    output mips_mem_pkg::data_rsp_t rsp,
    output mips_mem_pkg::ram_req_t  dreq
);
    import mips_mem_pkg::*;

    logic [5:0]  op;
    logic [1:0]  off;
    logic        is_lw, is_lh, is_lhu, is_lb, is_lbu;
    logic        is_sw, is_sh, is_sb;
    logic        is_load, is_store;
    logic        err_lw, err_sw;
    logic        load_ok, store_ok;
    logic [3:0]  be;
    logic [31:0] wdata_rep;

    logic        ld_pend_q;
    logic        ld_word_q, ld_half_q, ld_sign_q;
    logic [1:0]  ld_off_q;
    logic [15:0] half_sel;
    logic [7:0]  byte_sel;
    logic [31:0] fmt_data;

    assign op  = req.instr[31:26];
    assign off = req.addr[1:0];

    assign is_lw  = req.en && (op == OP_LW);
    assign is_lh  = req.en && (op == OP_LH);
    assign is_lhu = req.en && (op == OP_LHU);
    assign is_lb  = req.en && (op == OP_LB);
    assign is_lbu = req.en && (op == OP_LBU);
    assign is_sw  = req.en && (op == OP_SW);
    assign is_sh  = req.en && (op == OP_SH);
    assign is_sb  = req.en && (op == OP_SB);

    assign is_load  = is_lw | is_lh | is_lhu | is_lb | is_lbu;
    assign is_store = is_sw | is_sh | is_sb;

    // word needs offset 0, halfword needs an even offset
    assign err_lw = (is_lw && (off != 2'b00)) || ((is_lh || is_lhu) && off[0]);
    assign err_sw = (is_sw && (off != 2'b00)) || (is_sh && off[0]);

    assign load_ok  = is_load && !err_lw;
    assign store_ok = is_store && !err_sw;

    always_comb begin
        be = 4'b0000;
        if (is_sw) begin
            be = 4'b1111;
        end else if (is_sh) begin
            be = off[1] ? 4'b1100 : 4'b0011;  // upper or lower half
        end else if (is_sb) begin
            be = 4'b0001 << off;
        end
    end

    // same data in every lane, byte_wen picks the lane
    always_comb begin
        if (is_sb) begin
            wdata_rep = {4{req.wdata[7:0]}};
        end else if (is_sh) begin
            wdata_rep = {2{req.wdata[15:0]}};
        end else begin
            wdata_rep = req.wdata;
        end
    end

    always_comb begin
        dreq.en        = load_ok || store_ok;  // bad accesses never reach the RAM
        dreq.byte_wen  = store_ok ? be : 4'b0000;
        dreq.word_addr = WORD_ADDR_W'(req.addr[ADDR_W+1:2]);
        dreq.wdata     = wdata_rep;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ld_pend_q <= 1'b0;
        end else begin
            ld_pend_q <= load_ok;
        end
    end

    // load kind waits for the RAM word
    always_ff @(posedge clk) begin
        if (load_ok) begin
            ld_word_q <= is_lw;
            ld_half_q <= is_lh | is_lhu;
            ld_sign_q <= is_lh | is_lb;
            ld_off_q  <= off;
        end
    end

    assign half_sel = mem_rdata.halves[ld_off_q[1]];
    assign byte_sel = mem_rdata.bytes[ld_off_q];

    always_comb begin
        if (ld_word_q) begin
            fmt_data = mem_rdata.raw;
        end else if (ld_half_q) begin
            fmt_data = {{16{ld_sign_q & half_sel[15]}}, half_sel};
        end else begin
            fmt_data = {{24{ld_sign_q & byte_sel[7]}}, byte_sel};
        end
    end

    always_comb begin
        rsp.rvalid        = ld_pend_q;
        rsp.rdata         = fmt_data;
        rsp.addr_error_lw = err_lw;
        rsp.addr_error_sw = err_sw;
    end

    // a flagged access must not write any byte
    a_err_no_write: assert property (@(posedge clk) disable iff (rst)
        (rsp.addr_error_lw || rsp.addr_error_sw) |-> (dreq.byte_wen == 4'b0000));

    a_rvalid_after_load: assert property (@(posedge clk) disable iff (rst)
        rsp.rvalid |-> $past(dreq.en && (dreq.byte_wen == 4'b0000) && load_ok));

endmodule

`default_nettype wire

// File: hdl/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top #(
    parameter int ADDR_W = mips_mem_pkg::DEFAULT_ADDR_W
) (
    input  logic                    clk,
    input  logic                    rst,
    input  mips_mem_pkg::data_req_t req,
    input  logic                    fetch_start,
    input  logic [31:0]             fetch_pc,
    input  logic                    fetch_run,
    output mips_mem_pkg::data_rsp_t rsp,
    output logic                    instr_valid,
    output logic [31:0]             instr,
    output logic [31:0]             instr_pc
);
    import mips_mem_pkg::*;

    ram_req_t  dreq;
    ram_req_t  freq;
    ram_req_t  ram_req;
    mem_word_u ram_rdata;  // shared by both ports
    logic      fetch_grant;
    logic      fetch_rvalid;

    mem_control #(
        .ADDR_W    (ADDR_W)
    ) u_mem_control (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .mem_rdata (ram_rdata),
        .rsp       (rsp),
        .dreq      (dreq)
    );

    fetch_port #(
        .ADDR_W       (ADDR_W)
    ) u_fetch_port (
        .clk          (clk),
        .rst          (rst),
        .fetch_start  (fetch_start),
        .fetch_pc     (fetch_pc),
        .fetch_run    (fetch_run),
        .fetch_grant  (fetch_grant),
        .fetch_rvalid (fetch_rvalid),
        .mem_rdata    (ram_rdata),
        .freq         (freq),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc)
    );

    ram_arbiter #(
        .ADDR_W       (ADDR_W)
    ) u_ram_arbiter (
        .clk          (clk),
        .rst          (rst),
        .dreq         (dreq),
        .freq         (freq),
        .ram_req      (ram_req),
        .fetch_grant  (fetch_grant),
        .fetch_rvalid (fetch_rvalid)
    );

    data_ram #(
        .ADDR_W  (ADDR_W)
    ) u_data_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (ram_rdata)
    );

endmodule

`default_nettype wire

// File: hdl/mips_mem_pkg.sv
`default_nettype none

package mips_mem_pkg;

    localparam int DEFAULT_ADDR_W = 8;   // 256 words
    localparam int WORD_ADDR_W    = 30;  // full word space of a 32-bit byte address

    // memory opcodes, bits 31:26 of the instruction
    localparam logic [5:0] OP_LB  = 6'b100000;
    localparam logic [5:0] OP_LH  = 6'b100001;
    localparam logic [5:0] OP_LW  = 6'b100011;
    localparam logic [5:0] OP_LBU = 6'b100100;
    localparam logic [5:0] OP_LHU = 6'b100101;
    localparam logic [5:0] OP_SB  = 6'b101000;
    localparam logic [5:0] OP_SH  = 6'b101001;
    localparam logic [5:0] OP_SW  = 6'b101011;

    // one RAM word, seen whole, as bytes or as halfwords
    typedef union packed {
        logic [31:0]      raw;
        logic [3:0][7:0]  bytes;   // bytes[0] is addr offset 0
        logic [1:0][15:0] halves;  // halves[0] is offset 0
    } mem_word_u;

    // memory-stage access from the pipeline
    typedef struct packed {
        logic        en;
        logic [31:0] instr;
        logic [31:0] addr;   // byte address
        logic [31:0] wdata;
    } data_req_t;

    // result back to the pipeline
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
        logic        addr_error_lw;
        logic        addr_error_sw;
    } data_rsp_t;

    // one RAM access, only the low ADDR_W bits of word_addr reach the array
    typedef struct packed {
        logic                   en;
        logic [3:0]             byte_wen;  // zero means read
        logic [WORD_ADDR_W-1:0] word_addr;
        logic [31:0]            wdata;
    } ram_req_t;

endpackage

`default_nettype wire

// File: hdl/ram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module ram_arbiter #(
    parameter int ADDR_W = mips_mem_pkg::DEFAULT_ADDR_W
) (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_mem_pkg::ram_req_t dreq,
    input  mips_mem_pkg::ram_req_t freq,
    output mips_mem_pkg::ram_req_t ram_req,
    output logic                   fetch_grant,
    output logic                   fetch_rvalid
);
    import mips_mem_pkg::*;

    localparam logic [WORD_ADDR_W-1:0] ADDR_MASK =
        (WORD_ADDR_W'(1) << ADDR_W) - WORD_ADDR_W'(1);

    ram_req_t sel;
    logic     fetch_rd;

    // data side has fixed priority
    assign fetch_grant = freq.en && !dreq.en;
    assign fetch_rd    = fetch_grant && (freq.byte_wen == 4'b0000);

    always_comb begin
        sel               = dreq.en ? dreq : freq;
        ram_req           = sel;
        ram_req.word_addr = sel.word_addr & ADDR_MASK;  // trim to RAM depth
    end

    // owner of the word coming back next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_rvalid <= 1'b0;
        end else begin
            fetch_rvalid <= fetch_rd;
        end
    end

    // a data cycle never hands the returning word to the fetch side
    a_data_blocks_fetch: assert property (@(posedge clk) disable iff (rst)
        dreq.en |-> !fetch_grant ##1 !fetch_rvalid);

endmodule

`default_nettype wire
